// File: verilog/fpMulPkg.sv
`default_nettype none

package fpMulPkg;

	// Binary16 layout, sign on top
	localparam int expW = 5; // Biased exponent bits
	localparam int manW = 10; // Stored fraction, hidden bit implied
	localparam int bias = 15; // Exponent bias
	localparam int expMax = 31; // All ones exponent, reserved for inf and NaN

	// Unpack, mantissa, normalize, round
	localparam int pipeDepth = 4;

	// Encoded operand or result
	typedef logic [expW+manW:0] fp16T;

	// Significand with hidden bit at the MSB
	typedef logic [manW:0] sigT;

	// Full 11x11 significand product, value in [1,4)
	typedef logic [2*manW+1:0] prodT;

	// Signed exponent, room for both overflow and underflow
	typedef logic signed [expW+1:0] expSumT;

	// Exception flags, see bit positions below
	typedef logic [4:0] flagsT;

	// One-hot item class, see bit positions below
	typedef logic [3:0] classT;

	// Canonical quiet NaN, sign clear
	localparam fp16T qNaN = 16'h7E00;

	// Class bits
	localparam int clsNaN = 3; // NaN operand or zero times inf
	localparam int clsInf = 2; // Infinite result from an inf operand
	localparam int clsZero = 1; // Zero or subnormal operand
	localparam int clsSignal = 0; // Both operands normal, numeric path

	// Flag bits, MSB first
	localparam int flgInvalid = 4;
	localparam int flgInfIn = 3; // Infinite input
	localparam int flgOverflow = 2;
	localparam int flgUnderflow = 1;
	localparam int flgInexact = 0;

endpackage

`default_nettype wire

// File: verilog/fpMulUnpack.sv
`default_nettype none

// Stage 1, field split and operand classification
module fpMulUnpack (
	input wire clk,
	input wire rst,
	input wire inValid,
	output logic inReady,
	input wire fpMulPkg::fp16T a,
	input wire fpMulPkg::fp16T b,
	output logic outValid,
	input wire outReady,
	output logic sign,
	output logic [fpMulPkg::expW-1:0] expA,
	output logic [fpMulPkg::expW-1:0] expB,
	output fpMulPkg::sigT sigA,
	output fpMulPkg::sigT sigB,
	output fpMulPkg::classT cls
);

	// Returns {isNaN, isInf, isZero} of one operand
	function automatic logic [2:0] classify(input fpMulPkg::fp16T v);
		logic expOnes;
		logic expZero;
		logic fracNz;
		expOnes = &v[fpMulPkg::manW +: fpMulPkg::expW];
		expZero = ~|v[fpMulPkg::manW +: fpMulPkg::expW];
		fracNz = |v[fpMulPkg::manW-1:0];
		// Subnormals fold into zero
		return {expOnes & fracNz, expOnes & ~fracNz, expZero};
	endfunction

	logic aNaN, aInf, aZero;
	logic bNaN, bInf, bZero;
	logic nanItem; // Invalid operation
	fpMulPkg::classT clsNext;

	assign {aNaN, aInf, aZero} = classify(a);
	assign {bNaN, bInf, bZero} = classify(b);

	// Zero times inf is invalid as well
	assign nanItem = aNaN | bNaN | (aZero & bInf) | (aInf & bZero);

	// Combined class, exactly one bit set
	always_comb begin
		clsNext = '0;
		clsNext[fpMulPkg::clsNaN] = nanItem;
		clsNext[fpMulPkg::clsInf] = ~nanItem & (aInf | bInf);
		clsNext[fpMulPkg::clsZero] = ~nanItem & (aZero | bZero);
		clsNext[fpMulPkg::clsSignal] = ~(aNaN | aInf | aZero | bNaN | bInf | bZero);
	end

	// Free slot, or the item moves on this edge
	assign inReady = ~outValid | outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	// Payload only loads on a handshake
	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			sign <= a[fpMulPkg::expW+fpMulPkg::manW] ^ b[fpMulPkg::expW+fpMulPkg::manW];
			expA <= a[fpMulPkg::manW +: fpMulPkg::expW]; // Raw biased exponents
			expB <= b[fpMulPkg::manW +: fpMulPkg::expW];
			sigA <= {1'b1, a[fpMulPkg::manW-1:0]}; // Hidden bit attached
			sigB <= {1'b1, b[fpMulPkg::manW-1:0]};
			cls <= clsNext;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fpMulMantissa.sv
`default_nettype none

// Stage 2, significand multiply and exponent add
module fpMulMantissa (
	input wire clk,
	input wire rst,
	input wire inValid,
	output logic inReady,
	input wire inSign,
	input wire [fpMulPkg::expW-1:0] expA,
	input wire [fpMulPkg::expW-1:0] expB,
	input wire fpMulPkg::sigT sigA,
	input wire fpMulPkg::sigT sigB,
	input wire fpMulPkg::classT inCls,
	output logic outValid,
	input wire outReady,
	output logic outSign,
	output fpMulPkg::expSumT expSum,
	output fpMulPkg::prodT prod,
	output fpMulPkg::classT outCls
);

	fpMulPkg::prodT prodNext;
	fpMulPkg::expSumT sumNext;

	// Unsigned 11x11, top bit set when product is 2 or more
	assign prodNext = sigA * sigB;

	// True exponent sum, both biases removed
	assign sumNext = fpMulPkg::expSumT'({2'b00, expA})
		+ fpMulPkg::expSumT'({2'b00, expB})
		- fpMulPkg::expSumT'(2 * fpMulPkg::bias);

	assign inReady = ~outValid | outReady; // Bubble or drain

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			outSign <= inSign;
			expSum <= sumNext;
			prod <= prodNext;
			outCls <= inCls; // Class rides along untouched
		end
	end

endmodule

`default_nettype wire

// File: verilog/fpMulNormalize.sv
`default_nettype none

// Stage 3 normalizes by one bit and extracts guard and sticky
module fpMulNormalize (
	input wire clk,
	input wire rst,
	input wire inValid,
	output logic inReady,
	input wire inSign,
	input wire fpMulPkg::expSumT expSum,
	input wire fpMulPkg::prodT prod,
	input wire fpMulPkg::classT inCls,
	output logic outValid,
	input wire outReady,
	output logic outSign,
	output fpMulPkg::expSumT expNorm,
	output logic [fpMulPkg::manW-1:0] frac,
	output logic guard,
	output logic sticky,
	output fpMulPkg::classT outCls
);

	logic topBit; // Product in [2,4)
	logic lostBit; // Bit shifted out on normalize
	logic [2*fpMulPkg::manW-1:0] normProd; // Bits below the hidden bit
	logic [fpMulPkg::manW-1:0] fracNext;
	logic guardNext;
	logic stickyNext;
	fpMulPkg::expSumT expNext;

	assign topBit = prod[2*fpMulPkg::manW+1];

	// Right shift by one when the top bit is set
	assign normProd = topBit ? prod[2*fpMulPkg::manW:1] : prod[2*fpMulPkg::manW-1:0];
	assign lostBit = topBit & prod[0];

	assign fracNext = normProd[2*fpMulPkg::manW-1:fpMulPkg::manW];
	assign guardNext = normProd[fpMulPkg::manW-1]; // First bit below the LSB
	assign stickyNext = (|normProd[fpMulPkg::manW-2:0]) | lostBit; // OR of the rest

	// Biased exponent gains one on a shift
	assign expNext = topBit ? expSum + fpMulPkg::expSumT'(fpMulPkg::bias + 1)
		: expSum + fpMulPkg::expSumT'(fpMulPkg::bias);

	assign inReady = ~outValid | outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			outSign <= inSign;
			expNorm <= expNext; // Range checked in the round stage
			frac <= fracNext;
			guard <= guardNext;
			sticky <= stickyNext;
			outCls <= inCls;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fpMulRound.sv
`default_nettype none

// Stage 4, round to nearest even, range checks, specials and packing
module fpMulRound (
	input wire clk,
	input wire rst,
	input wire inValid,
	output logic inReady,
	input wire sign,
	input wire fpMulPkg::expSumT expNorm,
	input wire [fpMulPkg::manW-1:0] frac,
	input wire guard,
	input wire sticky,
	input wire fpMulPkg::classT cls,
	output logic outValid,
	input wire outReady,
	output fpMulPkg::fp16T result,
	output fpMulPkg::flagsT flags
);

	logic roundUp;
	logic [fpMulPkg::manW:0] fracSum; // Carry at the MSB
	fpMulPkg::expSumT expRnd; // Exponent after the carry
	logic isOvf;
	logic isUnf;
	logic inexact;
	fpMulPkg::fp16T resultNext;
	fpMulPkg::flagsT flagsNext;

	// Above half, or exactly half with odd LSB
	assign roundUp = guard & (sticky | frac[0]);
	assign fracSum = {1'b0, frac} + {{fpMulPkg::manW{1'b0}}, roundUp};

	// All ones fraction wraps to zero, exponent takes the carry
	assign expRnd = fracSum[fpMulPkg::manW] ? expNorm + fpMulPkg::expSumT'(1) : expNorm;

	assign isOvf = expRnd >= fpMulPkg::expSumT'(fpMulPkg::expMax);
	assign isUnf = expRnd <= fpMulPkg::expSumT'(0); // No subnormal results
	assign inexact = guard | sticky;

	always_comb begin
		// Signed zero, no flags
		resultNext = {sign, {(fpMulPkg::expW+fpMulPkg::manW){1'b0}}};
		flagsNext = '0;
		case (1'b1)
			cls[fpMulPkg::clsNaN]: begin
				resultNext = fpMulPkg::qNaN; // Sign dropped
				flagsNext[fpMulPkg::flgInvalid] = 1'b1;
			end
			cls[fpMulPkg::clsInf]: begin
				resultNext = {sign, {fpMulPkg::expW{1'b1}}, {fpMulPkg::manW{1'b0}}};
				flagsNext[fpMulPkg::flgInfIn] = 1'b1;
			end
			cls[fpMulPkg::clsZero]: begin
				flagsNext = '0; // Exact zero product
			end
			cls[fpMulPkg::clsSignal]: begin
				if (isOvf) begin
					resultNext = {sign, {fpMulPkg::expW{1'b1}}, {fpMulPkg::manW{1'b0}}};
					flagsNext[fpMulPkg::flgOverflow] = 1'b1;
					flagsNext[fpMulPkg::flgInexact] = 1'b1;
				end else if (isUnf) begin
					// Flush to signed zero
					flagsNext[fpMulPkg::flgUnderflow] = 1'b1;
					flagsNext[fpMulPkg::flgInexact] = 1'b1;
				end else begin
					resultNext = {sign, expRnd[fpMulPkg::expW-1:0],
						fracSum[fpMulPkg::manW-1:0]};
					flagsNext[fpMulPkg::flgInexact] = inexact;
				end
			end
			default: begin
				flagsNext = '0;
			end
		endcase
	end

	// Holds the item while the consumer stalls
	assign inReady = ~outValid | outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			result <= resultNext;
			flags <= flagsNext;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fpMul16.sv
`default_nettype none

// Four-stage binary16 multiplier, valid/ready on both sides
module fpMul16 (
	input wire clk,
	input wire rst,
	input wire inValid,
	output logic inReady,
	input wire fpMulPkg::fp16T a,
	input wire fpMulPkg::fp16T b,
	output logic outValid,
	input wire outReady,
	output fpMulPkg::fp16T result,
	output fpMulPkg::flagsT flags
);

	// Unpack to mantissa
	logic unpackValid;
	logic mantReady;
	logic unpackSign;
	logic [fpMulPkg::expW-1:0] unpackExpA;
	logic [fpMulPkg::expW-1:0] unpackExpB;
	fpMulPkg::sigT unpackSigA;
	fpMulPkg::sigT unpackSigB;
	fpMulPkg::classT unpackCls;

	// Mantissa to normalize
	logic mantValid;
	logic normReady;
	logic mantSign;
	fpMulPkg::expSumT mantExpSum;
	fpMulPkg::prodT mantProd;
	fpMulPkg::classT mantCls;

	// Normalize to round
	logic normValid;
	logic roundReady;
	logic normSign;
	fpMulPkg::expSumT normExp; // Biased, unclamped
	logic [fpMulPkg::manW-1:0] normFrac;
	logic normGuard;
	logic normSticky;
	fpMulPkg::classT normCls;

	fpMulUnpack uUnpack (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inReady(inReady), .a(a), .b(b),
		.outValid(unpackValid), .outReady(mantReady),
		.sign(unpackSign), .expA(unpackExpA), .expB(unpackExpB),
		.sigA(unpackSigA), .sigB(unpackSigB), .cls(unpackCls)
	);

	fpMulMantissa uMantissa (
		.clk(clk), .rst(rst),
		.inValid(unpackValid), .inReady(mantReady),
		.inSign(unpackSign), .expA(unpackExpA), .expB(unpackExpB),
		.sigA(unpackSigA), .sigB(unpackSigB), .inCls(unpackCls),
		.outValid(mantValid), .outReady(normReady),
		.outSign(mantSign), .expSum(mantExpSum), .prod(mantProd), .outCls(mantCls)
	);

	fpMulNormalize uNormalize (
		.clk(clk), .rst(rst),
		.inValid(mantValid), .inReady(normReady),
		.inSign(mantSign), .expSum(mantExpSum), .prod(mantProd), .inCls(mantCls),
		.outValid(normValid), .outReady(roundReady),
		.outSign(normSign), .expNorm(normExp), .frac(normFrac),
		.guard(normGuard), .sticky(normSticky), .outCls(normCls)
	);

	// Last stage drives the outputs directly
	fpMulRound uRound (
		.clk(clk), .rst(rst),
		.inValid(normValid), .inReady(roundReady),
		.sign(normSign), .expNorm(normExp), .frac(normFrac),
		.guard(normGuard), .sticky(normSticky), .cls(normCls),
		.outValid(outValid), .outReady(outReady),
		.result(result), .flags(flags)
	);

endmodule

`default_nettype wire

// File: tests/tbClock.sv
`default_nettype none

// Free-running clock and power-on reset for the testbench
module tbClock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk); // Two cycles in reset
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: tests/tbFpMul16.sv
`default_nettype none

module tbFpMul16;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst;
	logic inValid;
	logic inReady;
	fpMulPkg::fp16T a;
	fpMulPkg::fp16T b;
	logic outValid;
	logic outReady;
	fpMulPkg::fp16T result;
	fpMulPkg::flagsT flags;

	logic [31:0] lfsr = 32'hb4654a8a;
	int cycle = 0;
	int deadline = 0; // Watchdog limit in cycles
	logic latencyCheck = 1'b1; // Only while outReady stays high
	logic [20:0] expected[$]; // {result, flags} per accepted item
	int acceptCycle[$];
	logic held = 1'b0; // Output stalled on the last edge
	logic [20:0] heldOut;
	logic [20:0] want;

	tbClock uClock (.clk(clk), .rst(rst));

	fpMul16 u_fpMul16 (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inReady(inReady), .a(a), .b(b),
		.outValid(outValid), .outReady(outReady),
		.result(result), .flags(flags)
	);

	// Taps 32, 22, 2, 1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
			v = {v[14:0], lfsrStep()};
		return v;
	endfunction

	// Expected {result, flags}, integer arithmetic on the binary16 fields
	function automatic logic [20:0] reference(input logic [15:0] x, input logic [15:0] y);
		int ex, ey, fx, fy, e, p, keep, rem, half;
		logic s, nanX, nanY, infX, infY, zeroX, zeroY;
		ex = int'(x[14:10]);
		ey = int'(y[14:10]);
		fx = int'(x[9:0]);
		fy = int'(y[9:0]);
		s = x[15] ^ y[15];
		nanX = (ex == 31) && (fx != 0);
		nanY = (ey == 31) && (fy != 0);
		infX = (ex == 31) && (fx == 0);
		infY = (ey == 31) && (fy == 0);
		zeroX = (ex == 0); // Subnormals count as zero
		zeroY = (ey == 0);
		if (nanX || nanY || (zeroX && infY) || (infX && zeroY))
			return {16'h7E00, 5'b10000};
		if (infX || infY)
			return {s, 5'h1f, 10'h000, 5'b01000};
		if (zeroX || zeroY)
			return {s, 15'h0000, 5'b00000};
		p = (fx + 1024) * (fy + 1024); // Scaled by 2^20
		e = ex + ey - 15;
		if (p >= (1 << 21)) begin
			e = e + 1;
			keep = p >> 11;
			rem = p % 2048;
			half = 1024;
		end else begin
			keep = p >> 10;
			rem = p % 1024;
			half = 512;
		end
		if (rem > half || (rem == half && keep % 2 == 1))
			keep = keep + 1; // Nearest, ties to even
		if (keep == 2048) begin
			keep = 1024; // Significand overflow
			e = e + 1;
		end
		if (e >= 31)
			return {s, 5'h1f, 10'h000, 5'b00101};
		if (e <= 0)
			return {s, 15'h0000, 5'b00011};
		return {s, e[4:0], keep[9:0], 4'b0000, rem != 0};
	endfunction

	task automatic abortRun();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic armWatchdog(input int items);
		deadline = cycle + items * 20 + fpMulPkg::pipeDepth;
	endtask

	// Read at the falling edge, away from the monitor
	always @(negedge clk) begin
		if (cycle > deadline) begin
			$display("Timeout: the current test ran past its cycle budget of %0d", deadline);
			abortRun();
		end
	end

	// Scoreboard, hold check and latency check
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (!rst) begin
			if (held) begin
				checkValue("outValid", 32'(outValid), 32'd1);
				checkValue("result", 32'(result), 32'(heldOut[20:5]));
				checkValue("flags", 32'(flags), 32'(heldOut[4:0]));
			end
			held = outValid && !outReady;
			heldOut = {result, flags};
			if (outValid && outReady) begin
				if (expected.size() == 0) begin
					$display("Output handshake with no item outstanding");
					abortRun();
				end else begin
					want = expected.pop_front();
					checkValue("result", 32'(result), 32'(want[20:5]));
					checkValue("flags", 32'(flags), 32'(want[4:0]));
					if (latencyCheck)
						checkValue("latency", cycle - acceptCycle[0], 32'd4);
					void'(acceptCycle.pop_front());
				end
			end
			if (inValid && inReady) begin
				expected.push_back(reference(a, b));
				acceptCycle.push_back(cycle);
			end
		end
	end

	// One item, waits for its input handshake
	task automatic sendPair(input fpMulPkg::fp16T x, input fpMulPkg::fp16T y);
		inValid <= 1'b1;
		a <= x;
		b <= y;
		@(posedge clk);
		while (!inReady) @(posedge clk);
		inValid <= 1'b0;
	endtask

	// Hand-worked value checked against the model first
	task automatic expectPair(input fpMulPkg::fp16T x, input fpMulPkg::fp16T y,
		input logic [20:0] exp);
		checkValue("reference", 32'(reference(x, y)), 32'(exp));
		sendPair(x, y);
	endtask

	task automatic drain();
		@(negedge clk);
		while (expected.size() != 0) @(negedge clk);
		@(posedge clk); // Back on the driving edge
	endtask

	// Random operands, random inValid gaps, optional random outReady
	task automatic streamItems(input int count, input logic randReady);
		int offered;
		int accepted;
		offered = 0;
		accepted = 0;
		while (accepted < count) begin
			outReady <= randReady ? lfsrStep() : 1'b1;
			if (inValid && !inReady) begin
				inValid <= 1'b1; // Offer held until taken
			end else if (offered < count && lfsrStep()) begin
				a <= randomBits(16);
				b <= randomBits(16);
				inValid <= 1'b1;
				offered++;
			end else begin
				inValid <= 1'b0;
			end
			@(posedge clk);
			if (inValid && inReady)
				accepted++;
		end
		inValid <= 1'b0;
		outReady <= 1'b1;
	endtask

	task automatic exactProducts();
		armWatchdog(3);
		expectPair(16'h3E00, 16'h4000, {16'h4200, 5'b00000}); // 1.5 x 2.0
		expectPair(16'hC200, 16'h3800, {16'hBE00, 5'b00000}); // -3.0 x 0.5
		expectPair(16'h4500, 16'hC100, {16'hCA40, 5'b00000}); // 5.0 x -2.5
		drain();
	endtask

	task automatic roundNearestEven();
		armWatchdog(6);
		expectPair(16'h3C01, 16'h3E00, {16'h3E02, 5'b00001}); // Tie, odd LSB goes up
		expectPair(16'hBC01, 16'h3E00, {16'hBE02, 5'b00001});
		expectPair(16'h3C03, 16'h3E00, {16'h3E04, 5'b00001}); // Tie, even stays
		expectPair(16'h3C01, 16'h3C01, {16'h3C02, 5'b00001}); // Sticky only, down
		expectPair(16'h3E01, 16'h3E01, {16'h4082, 5'b00001}); // Above half, up
		expectPair(16'h3FFE, 16'h3C01, {16'h4000, 5'b00001}); // Carry into exponent
		drain();
	endtask

	task automatic rangeLimits();
		armWatchdog(7);
		expectPair(16'h7BFF, 16'h4000, {16'h7C00, 5'b00101});
		expectPair(16'hFBFF, 16'h4000, {16'hFC00, 5'b00101});
		expectPair(16'h0400, 16'h3800, {16'h0000, 5'b00011}); // Below min normal
		expectPair(16'h8400, 16'h3800, {16'h8000, 5'b00011});
		expectPair(16'h0400, 16'h3C00, {16'h0400, 5'b00000}); // Min normal kept
		expectPair(16'h0001, 16'h3C00, {16'h0000, 5'b00000}); // Subnormal input
		expectPair(16'h83FF, 16'h4000, {16'h8000, 5'b00000});
		drain();
	endtask

	task automatic specialCases();
		armWatchdog(8);
		expectPair(16'h7E00, 16'h3C00, {16'h7E00, 5'b10000});
		expectPair(16'hFC01, 16'h0000, {16'h7E00, 5'b10000}); // NaN sign dropped
		expectPair(16'h0000, 16'h7C00, {16'h7E00, 5'b10000});
		expectPair(16'h7C00, 16'h0001, {16'h7E00, 5'b10000}); // Inf x subnormal
		expectPair(16'h7C00, 16'hC000, {16'hFC00, 5'b01000});
		expectPair(16'hFC00, 16'hFC00, {16'h7C00, 5'b01000});
		expectPair(16'h8000, 16'h4500, {16'h8000, 5'b00000});
		expectPair(16'h0000, 16'h0000, {16'h0000, 5'b00000});
		drain();
	endtask

	task automatic randomStream();
		armWatchdog(200);
		streamItems(200, 1'b0);
		drain();
	endtask

	task automatic backPressure();
		int accepted;
		latencyCheck = 1'b0; // Pipeline is empty here
		armWatchdog(100);
		streamItems(100, 1'b1);
		drain();
		armWatchdog(6);
		outReady <= 1'b0;
		inValid <= 1'b1;
		a <= randomBits(16);
		b <= randomBits(16);
		accepted = 0;
		@(posedge clk);
		while (inReady) begin
			accepted++;
			a <= randomBits(16);
			b <= randomBits(16);
			@(posedge clk);
		end
		checkValue("accepted", accepted, 32'd4); // One per stage
		repeat (30) begin
			checkValue("inReady", 32'(inReady), 32'd0);
			@(posedge clk);
		end
		outReady <= 1'b1;
		@(posedge clk);
		while (!inReady) @(posedge clk); // Fifth item goes in
		inValid <= 1'b0;
		drain();
	endtask

	initial begin
		inValid = 1'b0;
		a = '0;
		b = '0;
		outReady = 1'b1;
		armWatchdog(1);
		@(posedge clk);
		while (rst) @(posedge clk);
		checkValue("outValid", 32'(outValid), 32'd0); // Empty after reset
		checkValue("inReady", 32'(inReady), 32'd1);
		exactProducts();
		roundNearestEven();
		rangeLimits();
		specialCases();
		randomStream();
		backPressure();
		if (expected.size() == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("%0d results never came out", expected.size());
			abortRun();
		end
	end

endmodule

`default_nettype wire

// File: build.f
verilog/fpMulPkg.sv
verilog/fpMulUnpack.sv
verilog/fpMulMantissa.sv
verilog/fpMulNormalize.sv
verilog/fpMulRound.sv
verilog/fpMul16.sv
tests/tbClock.sv
tests/tbFpMul16.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbFpMul16
RTL_TOP ?= fpMul16
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
